/* logic/fir_defines.svh */
`ifndef FIR_DEFINES_SVH
`define FIR_DEFINES_SVH

// filter shape
`define FIR_TAP_NUM   11      // taps h[0]..h[10]
`define FIR_DATA_W    32      // sample and coefficient width

// axi-lite side
`define FIR_ADDR_W    12      // only the low byte is decoded

// register map, low byte of the address
`define FIR_REG_CTRL  8'h00   // start, done, idle, stream flags
`define FIR_REG_LEN   8'h10   // number of samples in one run
`define FIR_REG_TAP0  8'h80   // tap i at 0x80 + 4*i

// multiply-accumulate pipeline stages
`define FIR_MAC_DEPTH 2

`endif

/* logic/fir_cfg_pkg.sv */
`include "fir_defines.svh"

package fir_cfg_pkg;

    // control register at 0x00, start in bit 0
    typedef struct packed {
        logic sm_valid;   // bit 5, result waiting on sm_*
        logic ss_ready;   // bit 4, core takes a sample
        logic rsvd;       // bit 3, reads zero
        logic idle;       // bit 2
        logic done;       // bit 1
        logic start;      // bit 0
    } ap_status_t;

    // core phase
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        RUN  = 2'd1,
        DONE = 2'd2
    } core_state_t;

    // one accepted axi-lite write, valid for the accept cycle only
    typedef struct packed {
        logic                   wr;       // write strobe
        logic [7:0]             offset;   // low address byte
        logic [`FIR_DATA_W-1:0] data;
    } reg_wr_t;

endpackage

/* logic/fir_stream_pkg.sv */
`include "fir_defines.svh"

package fir_stream_pkg;

    typedef logic [`FIR_DATA_W-1:0] sample_t;   // x[n] and y[n]
    typedef logic [`FIR_DATA_W-1:0] coef_t;     // h[i]

    // 0..10, picks h[i] and x[n-i]
    typedef logic [3:0] tap_idx_t;

    // one step of the mac sequence
    typedef struct packed {
        logic valid;
        logic first;   // restart the sum
        logic last;    // sum complete after this term
    } mac_cmd_t;

endpackage

/* logic/axil_regs.sv */
`include "fir_defines.svh"

module axil_regs (
    input  logic                        axis_clk,
    input  logic                        axis_rst_n,
    // write channels
    input  logic                        awvalid,
    input  logic [`FIR_ADDR_W-1:0]      awaddr,
    output logic                        awready,
    input  logic                        wvalid,
    input  logic [`FIR_DATA_W-1:0]      wdata,
    output logic                        wready,
    // read channels
    input  logic                        arvalid,
    input  logic [`FIR_ADDR_W-1:0]      araddr,
    output logic                        arready,
    output logic                        rvalid,
    input  logic                        rready,
    output logic [`FIR_DATA_W-1:0]      rdata,
    // core side
    output fir_cfg_pkg::reg_wr_t        reg_wr,
    output logic                        rd_ctrl,
    output fir_stream_pkg::tap_idx_t    tap_rd_idx,
    input  fir_stream_pkg::coef_t       tap_rd,
    input  fir_cfg_pkg::ap_status_t     status,
    input  logic [`FIR_DATA_W-1:0]      length
);
    import fir_cfg_pkg::*;
    import fir_stream_pkg::*;

    logic                   wr_acc_q;     // one-cycle write accept
    logic                   arready_q;
    logic                   rvalid_q;
    logic                   rd_issue;     // read accepted this edge
    logic [7:0]             rd_off;
    logic [7:0]             rd_tap_off;   // offset relative to tap 0
    logic                   rd_tap_hit;
    logic [`FIR_DATA_W-1:0] rd_word;
    logic [`FIR_DATA_W-1:0] rdata_q;

    // both valids seen, answer on the next cycle only
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            wr_acc_q <= 1'b0;
        end else begin
            wr_acc_q <= awvalid && wvalid && !wr_acc_q;
        end
    end

    assign awready = wr_acc_q;
    assign wready  = wr_acc_q;

    // master holds addr and data until it sees the readies
    assign reg_wr.wr     = wr_acc_q;
    assign reg_wr.offset = awaddr[7:0];
    assign reg_wr.data   = wdata;

    assign rd_off     = araddr[7:0];
    assign rd_tap_off = rd_off - `FIR_REG_TAP0;
    assign rd_tap_hit = (rd_off >= `FIR_REG_TAP0) && (rd_tap_off[7:2] < `FIR_TAP_NUM) &&
                        (rd_tap_off[1:0] == 2'b00);
    assign tap_rd_idx = tap_idx_t'(rd_tap_off[5:2]);

    // read data select
    always_comb begin
        rd_word = '0;
        if (rd_off == `FIR_REG_CTRL) begin
            rd_word[$bits(ap_status_t)-1:0] = status;   // zero-extended
        end else if (rd_off == `FIR_REG_LEN) begin
            rd_word = length;
        end else if (rd_tap_hit) begin
            rd_word = tap_rd;
        end
    end

    assign rd_issue = arvalid && !arready_q && !rvalid_q;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            arready_q <= 1'b0;
            rvalid_q  <= 1'b0;
        end else begin
            arready_q <= rd_issue;
            if (rd_issue) begin
                rvalid_q <= 1'b1;
            end else if (rready) begin
                rvalid_q <= 1'b0;   // held until the master takes it
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        if (rd_issue) begin
            rdata_q <= rd_word;
        end
    end

    assign arready = arready_q;
    assign rvalid  = rvalid_q;
    assign rdata   = rdata_q;
    assign rd_ctrl = arready_q && (rd_off == `FIR_REG_CTRL);   // status was sampled already

    a_rvalid_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

/* logic/fir_ctrl.sv */
`include "fir_defines.svh"

module fir_ctrl (
    input  logic                        axis_clk,
    input  logic                        axis_rst_n,
    // register side
    input  fir_cfg_pkg::reg_wr_t        reg_wr,
    input  logic                        rd_ctrl,
    output fir_cfg_pkg::ap_status_t     status,
    output logic [`FIR_DATA_W-1:0]      length,
    output logic                        tap_we,
    // streams
    input  logic                        ss_tvalid,
    output logic                        ss_tready,
    input  logic                        sm_tready,
    output logic                        sm_tvalid,
    output logic                        sm_tlast,
    // datapath
    output logic                        ring_wr,
    output logic                        ring_clr,
    output fir_stream_pkg::tap_idx_t    tap_idx,
    output fir_stream_pkg::mac_cmd_t    mac_cmd,
    input  logic                        mac_done
);
    import fir_cfg_pkg::*;
    import fir_stream_pkg::*;

    core_state_t            state_q;
    core_state_t            state_d;
    logic                   start_req;   // start write that lands
    logic                   len_req;
    logic                   ss_xfer;
    logic                   sm_xfer;
    logic                   last_xfer;
    logic                   busy_q;      // one sample in flight
    logic                   arm_q;       // ring written, taps start next
    logic                   tap_run_q;
    tap_idx_t               tap_idx_q;
    logic                   sm_tvalid_q;
    logic [`FIR_DATA_W-1:0] len_q;
    logic [`FIR_DATA_W-1:0] out_cnt_q;   // outputs transferred this run

    // config writes only land while idle
    assign start_req = reg_wr.wr && (reg_wr.offset == `FIR_REG_CTRL) && reg_wr.data[0] &&
                       (state_q == IDLE);
    assign len_req   = reg_wr.wr && (reg_wr.offset == `FIR_REG_LEN) && (state_q == IDLE);
    assign tap_we    = (state_q == IDLE);

    assign ss_tready = (state_q == RUN) && !busy_q;
    assign ss_xfer   = ss_tvalid && ss_tready;
    assign sm_xfer   = sm_tvalid_q && sm_tready;
    assign sm_tvalid = sm_tvalid_q;
    assign sm_tlast  = sm_tvalid_q && (out_cnt_q + 32'd1 == len_q);   // output number len
    assign last_xfer = sm_xfer && sm_tlast;

    assign ring_wr  = ss_xfer;     // newest sample straight from ss_tdata
    assign ring_clr = start_req;   // history starts from zeros

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: if (start_req) state_d = RUN;
            RUN:  if (last_xfer) state_d = DONE;
            DONE: if (rd_ctrl) state_d = IDLE;   // done seen by the host
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state_q   <= IDLE;
            len_q     <= '0;
            out_cnt_q <= '0;
        end else begin
            state_q <= state_d;
            if (len_req) begin
                len_q <= reg_wr.data;
            end
            if (start_req) begin
                out_cnt_q <= '0;
            end else if (sm_xfer) begin
                out_cnt_q <= out_cnt_q + 32'd1;
            end
        end
    end

    // per-sample sequence: accept, ring write, 11 taps, mac drain
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            busy_q      <= 1'b0;
            arm_q       <= 1'b0;
            tap_run_q   <= 1'b0;
            tap_idx_q   <= '0;
            sm_tvalid_q <= 1'b0;
        end else begin
            arm_q <= ss_xfer;
            if (ss_xfer) begin
                busy_q <= 1'b1;
            end else if (sm_xfer) begin
                busy_q <= 1'b0;   // next sample only after the result leaves
            end
            if (arm_q) begin
                tap_run_q <= 1'b1;
                tap_idx_q <= '0;
            end else if (tap_run_q) begin
                if (tap_idx_q == tap_idx_t'(`FIR_TAP_NUM - 1)) begin
                    tap_run_q <= 1'b0;
                end else begin
                    tap_idx_q <= tap_idx_q + 4'd1;
                end
            end
            if (mac_done) begin
                sm_tvalid_q <= 1'b1;
            end else if (sm_xfer) begin
                sm_tvalid_q <= 1'b0;
            end
        end
    end

    assign tap_idx       = tap_idx_q;
    assign mac_cmd.valid = tap_run_q;
    assign mac_cmd.first = tap_run_q && (tap_idx_q == '0);
    assign mac_cmd.last  = tap_run_q && (tap_idx_q == tap_idx_t'(`FIR_TAP_NUM - 1));

    assign status.sm_valid = sm_tvalid_q;
    assign status.ss_ready = ss_tready;
    assign status.rsvd     = 1'b0;
    assign status.idle     = (state_q == IDLE);
    assign status.done     = (state_q == DONE);
    assign status.start    = start_req;
    assign length          = len_q;

    a_sm_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        sm_tvalid && !sm_tready |=> sm_tvalid && $stable(sm_tlast));

    // no new sample while taps or a result are still pending
    a_ss_gate: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        ss_tready |-> (state_q == RUN) && !sm_tvalid_q && !tap_run_q && !arm_q);

endmodule

/* logic/tap_store.sv */
`include "fir_defines.svh"

module tap_store (
    input  logic                        axis_clk,
    input  fir_cfg_pkg::reg_wr_t        reg_wr,
    input  logic                        tap_we,     // high only while idle
    input  fir_stream_pkg::tap_idx_t    mac_idx,
    output fir_stream_pkg::coef_t       mac_coef,
    input  fir_stream_pkg::tap_idx_t    lite_idx,
    output fir_stream_pkg::coef_t       lite_coef
);
    import fir_cfg_pkg::*;
    import fir_stream_pkg::*;

    coef_t      taps [`FIR_TAP_NUM];   // h[0]..h[10]
    logic [7:0] wr_off;                // offset relative to tap 0
    logic       wr_hit;

    assign wr_off = reg_wr.offset - `FIR_REG_TAP0;
    assign wr_hit = reg_wr.wr && tap_we && (reg_wr.offset >= `FIR_REG_TAP0) &&
                    (wr_off[7:2] < `FIR_TAP_NUM) && (wr_off[1:0] == 2'b00);

    // written from offsets 0x80 to 0xa8
    always_ff @(posedge axis_clk) begin
        if (wr_hit) begin
            taps[wr_off[5:2]] <= reg_wr.data;
        end
    end

    // two async read ports
    assign mac_coef  = (mac_idx < `FIR_TAP_NUM) ? taps[mac_idx] : '0;
    assign lite_coef = (lite_idx < `FIR_TAP_NUM) ? taps[lite_idx] : '0;

endmodule

/* logic/sample_ring.sv */
`include "fir_defines.svh"

module sample_ring (
    input  logic                        axis_clk,
    input  logic                        axis_rst_n,
    input  logic                        wr,
    input  logic                        clr,
    input  fir_stream_pkg::sample_t     wr_data,
    input  fir_stream_pkg::tap_idx_t    idx,       // 0 = newest
    output fir_stream_pkg::sample_t     rd_data
);
    import fir_stream_pkg::*;

    sample_t    hist [`FIR_TAP_NUM];
    tap_idx_t   wptr_q;    // next slot to fill
    logic [4:0] rd_sum;    // wptr - 1 - idx + 11, before wrap
    logic [4:0] rd_pos;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            wptr_q <= '0;
        end else if (clr) begin
            wptr_q <= '0;
        end else if (wr) begin
            if (wptr_q == tap_idx_t'(`FIR_TAP_NUM - 1)) begin
                wptr_q <= '0;
            end else begin
                wptr_q <= wptr_q + 4'd1;
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        if (clr) begin
            for (int i = 0; i < `FIR_TAP_NUM; i++) begin
                hist[i] <= '0;   // x before the first sample counts as 0
            end
        end else if (wr) begin
            hist[wptr_q] <= wr_data;
        end
    end

    // older by idx, modulo 11
    assign rd_sum  = {1'b0, wptr_q} + 5'(`FIR_TAP_NUM - 1) - {1'b0, idx};
    assign rd_pos  = (rd_sum >= 5'(`FIR_TAP_NUM)) ? rd_sum - 5'(`FIR_TAP_NUM) : rd_sum;
    assign rd_data = hist[rd_pos[3:0]];

endmodule

/* logic/fir_mac.sv */
`include "fir_defines.svh"

module fir_mac (
    input  logic                        axis_clk,
    input  logic                        axis_rst_n,
    input  fir_stream_pkg::mac_cmd_t    cmd,
    input  fir_stream_pkg::coef_t       coef,
    input  fir_stream_pkg::sample_t     sample,
    output fir_stream_pkg::sample_t     sum,
    output logic                        done
);
    import fir_stream_pkg::*;

    mac_cmd_t s1_cmd_q;   // command beside the product
    sample_t  prod_q;     // low 32 bits of h[i] * x[n-i]
    sample_t  acc_q;
    logic     done_q;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            s1_cmd_q <= '0;
            done_q   <= 1'b0;
        end else begin
            s1_cmd_q <= cmd;
            done_q   <= s1_cmd_q.valid && s1_cmd_q.last;   // single-cycle pulse
        end
    end

    // product in stage 1 and sum in stage 2
    always_ff @(posedge axis_clk) begin
        prod_q <= coef * sample;   // wraps mod 2^32
        if (s1_cmd_q.valid) begin
            if (s1_cmd_q.first) begin
                acc_q <= prod_q;
            end else begin
                acc_q <= acc_q + prod_q;
            end
        end
    end

    assign sum  = acc_q;   // held until the next first
    assign done = done_q;

    // every later term directly follows a term of the same sum
    a_mac_seq: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        cmd.valid && !cmd.first |-> $past(cmd.valid) && !$past(cmd.last));

endmodule

/* logic/fir_top.sv */
`include "fir_defines.svh"

module fir_top (
    input  logic                    axis_clk,
    input  logic                    axis_rst_n,
    // axi-lite
    input  logic                    awvalid,
    input  logic [`FIR_ADDR_W-1:0]  awaddr,
    output logic                    awready,
    input  logic                    wvalid,
    input  logic [`FIR_DATA_W-1:0]  wdata,
    output logic                    wready,
    input  logic                    arvalid,
    input  logic [`FIR_ADDR_W-1:0]  araddr,
    output logic                    arready,
    output logic                    rvalid,
    input  logic                    rready,
    output logic [`FIR_DATA_W-1:0]  rdata,
    // sample stream in
    input  logic                    ss_tvalid,
    input  logic [`FIR_DATA_W-1:0]  ss_tdata,
    output logic                    ss_tready,
    // result stream out
    output logic                    sm_tvalid,
    output logic [`FIR_DATA_W-1:0]  sm_tdata,
    output logic                    sm_tlast,
    input  logic                    sm_tready
);
    fir_cfg_pkg::reg_wr_t           reg_wr;
    fir_cfg_pkg::ap_status_t        status;
    logic [`FIR_DATA_W-1:0]         length;
    logic                           rd_ctrl;
    logic                           tap_we;
    fir_stream_pkg::tap_idx_t       tap_rd_idx;   // host readback
    fir_stream_pkg::coef_t          tap_rd;
    fir_stream_pkg::tap_idx_t       tap_idx;      // mac sequence
    fir_stream_pkg::coef_t          mac_coef;
    fir_stream_pkg::sample_t        mac_sample;
    fir_stream_pkg::mac_cmd_t       mac_cmd;
    logic                           mac_done;
    logic                           ring_wr;
    logic                           ring_clr;

    axil_regs axil_regs_i (
        .axis_clk, .axis_rst_n,
        .awvalid, .awaddr, .awready, .wvalid, .wdata, .wready,
        .arvalid, .araddr, .arready, .rvalid, .rready, .rdata,
        .reg_wr, .rd_ctrl, .tap_rd_idx, .tap_rd, .status, .length
    );

    fir_ctrl fir_ctrl_i (
        .axis_clk, .axis_rst_n,
        .reg_wr, .rd_ctrl, .status, .length, .tap_we,
        .ss_tvalid, .ss_tready, .sm_tready, .sm_tvalid, .sm_tlast,
        .ring_wr, .ring_clr, .tap_idx, .mac_cmd, .mac_done
    );

    tap_store tap_store_i (
        .axis_clk, .reg_wr, .tap_we,
        .mac_idx(tap_idx), .mac_coef, .lite_idx(tap_rd_idx), .lite_coef(tap_rd)
    );

    sample_ring sample_ring_i (
        .axis_clk, .axis_rst_n,
        .wr(ring_wr), .clr(ring_clr), .wr_data(ss_tdata), .idx(tap_idx), .rd_data(mac_sample)
    );

    fir_mac fir_mac_i (
        .axis_clk, .axis_rst_n,
        .cmd(mac_cmd), .coef(mac_coef), .sample(mac_sample), .sum(sm_tdata), .done(mac_done)
    );

endmodule

/* verification/fir_tb.sv */
`include "fir_defines.svh"

module fir_tb;
    import fir_stream_pkg::*;

    localparam int N_SAMPLES = 24;
    localparam int N_REG_OPS = 36;
    localparam int OUT_LAT   = 1 + `FIR_TAP_NUM + `FIR_MAC_DEPTH;   // ring write, taps, mac
    localparam int CYC_LIMIT = 2 * N_SAMPLES * (OUT_LAT + 20) + N_REG_OPS * 20 + 200;

    // status words, bit 0 start, 1 done, 2 idle, 4 ss_ready, 5 sm_valid
    localparam logic [31:0] ST_IDLE = 32'h04;
    localparam logic [31:0] ST_DONE = 32'h02;
    localparam logic [31:0] ST_RUN  = 32'h10;   // running, ready for a sample

    typedef struct packed {
        logic        wr;
        logic [7:0]  off;
        logic [31:0] data;
        logic [31:0] exp;    // read ops only
    } reg_op_t;

    logic                   axis_clk;
    logic                   axis_rst_n;
    logic                   awvalid, wvalid, arvalid, rready;
    logic [`FIR_ADDR_W-1:0] awaddr, araddr;
    logic [31:0]            wdata, rdata;
    logic                   awready, wready, arready, rvalid;
    logic                   ss_tvalid, ss_tready;
    logic [31:0]            ss_tdata;
    logic                   sm_tvalid, sm_tready, sm_tlast;
    logic [31:0]            sm_tdata;

    reg_op_t     reg_ops [$];
    string       reg_names [$];
    coef_t       h_model [`FIR_TAP_NUM];   // taps the core should hold
    sample_t     run_in [N_SAMPLES];
    logic [31:0] lfsr;
    int          cyc;
    bit          running;

    sample_t samples [N_SAMPLES] = '{
        32'h00000001, 32'h00000002, 32'hffffffff, 32'h00000010, 32'h00001234, 32'h80000000,
        32'h7fffffff, 32'h00000000, 32'h00000005, 32'hfffffff0, 32'h0badcafe, 32'h00000003,
        32'h00010001, 32'h00000007, 32'hdeadbeef, 32'h00000100, 32'h55aa55aa, 32'h00000009,
        32'hffff0000, 32'h0000ffff, 32'h00000021, 32'h13579bdf, 32'h00000002, 32'hfffffffe
    };
    coef_t tap_init [`FIR_TAP_NUM] = '{
        32'h00000001, 32'hfffffffe, 32'h00000003, 32'h00010005, 32'h7fffffff, 32'h00000000,
        32'h80000001, 32'h0000abcd, 32'hffffff00, 32'h12345678, 32'h00000009
    };

    fir_top fir_top_i (
        .axis_clk, .axis_rst_n,
        .awvalid, .awaddr, .awready, .wvalid, .wdata, .wready,
        .arvalid, .araddr, .arready, .rvalid, .rready, .rdata,
        .ss_tvalid, .ss_tdata, .ss_tready,
        .sm_tvalid, .sm_tdata, .sm_tlast, .sm_tready
    );

    initial begin
        axis_clk = 1'b0;
        forever #10 axis_clk = ~axis_clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("MISMATCH %s expected %h actual %h", name, exp, act);
        $display("Errors found");
        $fatal(1, "run stopped at first error");
    endtask

    // edge count, read only at negedges
    always @(posedge axis_clk) begin
        cyc = cyc + 1;
        if (cyc > CYC_LIMIT) begin
            fail_run($sformatf("timeout, run still busy after %0d cycles", CYC_LIMIT));
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // y[n] = sum h[i] * x[n-i] mod 2^32, zero history before x[0]
    function automatic sample_t fir_model(input int n);
        sample_t acc;
        acc = '0;
        for (int i = 0; i < `FIR_TAP_NUM; i++) begin
            if (n - i >= 0) begin
                acc = acc + h_model[i] * run_in[n - i];
            end
        end
        return acc;
    endfunction

    task automatic add_op(input string name, input bit wr, input logic [7:0] off,
                          input logic [31:0] data, input logic [31:0] exp);
        reg_ops.push_back({wr, off, data, exp});
        reg_names.push_back(name);
    endtask

    task automatic axil_write(input logic [7:0] off, input logic [31:0] data);
        @(posedge axis_clk);
        awaddr  <= {{(`FIR_ADDR_W - 8){1'b0}}, off};
        wdata   <= data;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        do @(negedge axis_clk); while (!awready);
        assert (wready) else fail_run("wready did not rise together with awready");
        @(posedge axis_clk);   // write lands on this edge
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
    endtask

    task automatic axil_read(input logic [7:0] off, output logic [31:0] data);
        @(posedge axis_clk);
        araddr  <= {{(`FIR_ADDR_W - 8){1'b0}}, off};
        arvalid <= 1'b1;
        do @(negedge axis_clk); while (!arready);
        assert (rvalid) else fail_run("rvalid did not rise together with arready");
        data = rdata;
        @(posedge axis_clk);   // rready is tied high, read ends here
        arvalid <= 1'b0;
    endtask

    task automatic apply_regs(input int first, input int last);
        logic [31:0] rd;
        int          t;
        for (int k = first; k <= last; k++) begin
            if (reg_ops[k].wr) begin
                axil_write(reg_ops[k].off, reg_ops[k].data);
                t = (int'(reg_ops[k].off) - int'(`FIR_REG_TAP0)) / 4;
                if (reg_ops[k].off >= `FIR_REG_TAP0 && t < `FIR_TAP_NUM && !running) begin
                    h_model[t] = reg_ops[k].data;   // only lands while idle
                end
                if (reg_ops[k].off == `FIR_REG_CTRL && reg_ops[k].data[0]) begin
                    running = 1'b1;
                end
            end else begin
                axil_read(reg_ops[k].off, rd);
                assert (rd == reg_ops[k].exp) else report_mismatch(reg_names[k],
                                                                   reg_ops[k].exp, rd);
                if (reg_ops[k].off == `FIR_REG_CTRL && reg_ops[k].exp[1]) begin
                    running = 1'b0;   // done read returns the core to idle
                end
            end
        end
    endtask

    task automatic run_stream(input string name, input bit reverse);
        int      in_idx;
        int      out_idx;
        int      xfer_edge;
        bit      ss_fire;
        bit      sm_fire;
        bit      prev_valid;
        bit      prev_stall;
        sample_t prev_data;
        sample_t exp;
        for (int n = 0; n < N_SAMPLES; n++) begin
            run_in[n] = reverse ? samples[N_SAMPLES - 1 - n] : samples[n];
        end
        in_idx     = 0;
        out_idx    = 0;
        xfer_edge  = 0;
        prev_valid = 1'b0;
        prev_stall = 1'b0;
        prev_data  = '0;
        @(posedge axis_clk);
        ss_tdata  <= run_in[0];
        ss_tvalid <= 1'b1;
        while (out_idx < N_SAMPLES) begin
            @(negedge axis_clk);
            ss_fire = ss_tvalid && ss_tready;
            sm_fire = sm_tvalid && sm_tready;
            if (prev_stall) begin   // back-pressure hold
                assert (sm_tvalid && sm_tdata == prev_data) else report_mismatch(
                    $sformatf("%s hold %0d", name, out_idx), prev_data, sm_tdata);
            end
            if (sm_tvalid && !prev_valid) begin
                assert (cyc == xfer_edge + OUT_LAT) else report_mismatch(
                    $sformatf("%s latency %0d", name, out_idx), xfer_edge + OUT_LAT, cyc);
            end
            if (sm_tvalid) begin
                assert (sm_tlast == (out_idx == N_SAMPLES - 1)) else report_mismatch(
                    $sformatf("%s tlast %0d", name, out_idx), out_idx == N_SAMPLES - 1,
                    sm_tlast);
            end
            if (sm_fire) begin
                exp = fir_model(out_idx);
                assert (sm_tdata == exp) else report_mismatch(
                    $sformatf("%s output %0d", name, out_idx), exp, sm_tdata);
                out_idx++;
            end
            if (ss_fire) begin
                xfer_edge = cyc + 1;   // transfer on the coming edge
                in_idx++;
            end
            prev_valid = sm_tvalid;
            prev_stall = sm_tvalid && !sm_tready;
            prev_data  = sm_tdata;
            @(posedge axis_clk);
            if (ss_fire && in_idx < N_SAMPLES) begin
                ss_tdata <= run_in[in_idx];
            end else if (ss_fire) begin
                ss_tvalid <= 1'b0;
                ss_tdata  <= '0;
            end
            lfsr = lfsr_step(lfsr);
            sm_tready <= lfsr[0];
        end
    endtask

    initial begin
        int mark_a;
        int mark_b;
        axis_rst_n = 1'b0;
        awvalid    = 1'b0;
        wvalid     = 1'b0;
        arvalid    = 1'b0;
        rready     = 1'b1;
        awaddr     = '0;
        araddr     = '0;
        wdata      = '0;
        ss_tvalid  = 1'b0;
        ss_tdata   = '0;
        sm_tready  = 1'b0;
        lfsr       = 32'h41e584c9;
        cyc        = 0;
        running    = 1'b0;

        // register table, reads carry the expected word
        add_op("status after reset", 1'b0, `FIR_REG_CTRL, '0, ST_IDLE);
        for (int i = 0; i < `FIR_TAP_NUM; i++) begin
            add_op($sformatf("tap %0d write", i), 1'b1, `FIR_REG_TAP0 + 8'(4 * i),
                   tap_init[i], '0);
        end
        add_op("length write", 1'b1, `FIR_REG_LEN, N_SAMPLES, '0);
        for (int i = 0; i < `FIR_TAP_NUM; i++) begin
            add_op($sformatf("tap %0d readback", i), 1'b0, `FIR_REG_TAP0 + 8'(4 * i),
                   '0, tap_init[i]);
        end
        add_op("length readback", 1'b0, `FIR_REG_LEN, '0, N_SAMPLES);
        add_op("start run 1", 1'b1, `FIR_REG_CTRL, 32'h1, '0);
        add_op("status while running", 1'b0, `FIR_REG_CTRL, '0, ST_RUN);
        add_op("tap 3 write in run", 1'b1, `FIR_REG_TAP0 + 8'd12, 32'hdeadbeef, '0);
        add_op("length write in run", 1'b1, `FIR_REG_LEN, 32'd5, '0);
        add_op("tap 3 keeps old value", 1'b0, `FIR_REG_TAP0 + 8'd12, '0, tap_init[3]);
        add_op("length keeps old value", 1'b0, `FIR_REG_LEN, '0, N_SAMPLES);
        mark_a = reg_ops.size();
        add_op("done after run 1", 1'b0, `FIR_REG_CTRL, '0, ST_DONE);
        add_op("idle after done 1", 1'b0, `FIR_REG_CTRL, '0, ST_IDLE);
        add_op("start run 2", 1'b1, `FIR_REG_CTRL, 32'h1, '0);
        mark_b = reg_ops.size();
        add_op("done after run 2", 1'b0, `FIR_REG_CTRL, '0, ST_DONE);
        add_op("idle after done 2", 1'b0, `FIR_REG_CTRL, '0, ST_IDLE);

        repeat (2) @(posedge axis_clk);
        axis_rst_n <= 1'b1;
        @(negedge axis_clk);
        assert (!ss_tready) else report_mismatch("ss_tready after reset", 0, ss_tready);
        assert (!sm_tvalid) else report_mismatch("sm_tvalid after reset", 0, sm_tvalid);

        apply_regs(0, mark_a - 1);
        run_stream("run 1", 1'b0);
        apply_regs(mark_a, mark_b - 1);
        run_stream("run 2", 1'b1);   // reversed samples, history from zeros
        apply_regs(mark_b, reg_ops.size() - 1);

        $display("No errors");
        $finish;
    end

endmodule

/* sim.f */
+incdir+logic
logic/fir_cfg_pkg.sv
logic/fir_stream_pkg.sv
logic/axil_regs.sv
logic/fir_ctrl.sv
logic/tap_store.sv
logic/sample_ring.sv
logic/fir_mac.sv
logic/fir_top.sv
verification/fir_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := fir_tb
FILELIST   := sim.f
BUILD_DIR  := obj_dir
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert -Wall

SOURCES := $(shell grep -v '^+' $(FILELIST)) logic/fir_defines.svh

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
